/* source/mipsPkg.sv */
package mipsPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0]       RESET_PC = 32'hBFC0_0000;
    localparam logic [REG_ADDR_W-1:0] RA_REG   = 5'd31;  // link register for jal

    // primary opcode field, R-format group lives under SPECIAL
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_J    = 6'h02, OP_JAL  = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE  = 6'h05, OP_ADDIU = 6'h09,
        OP_ANDI    = 6'h0C, OP_ORI  = 6'h0D, OP_LUI  = 6'h0F,
        OP_LB      = 6'h20, OP_LW   = 6'h23, OP_LBU  = 6'h24,
        OP_SB      = 6'h28, OP_SW   = 6'h2B
    } opcodeE;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00, FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24,
        FN_OR  = 6'h25, FN_XOR  = 6'h26, FN_SLT  = 6'h2A
    } functE;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOpE;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB
    } memOpE;

    typedef enum logic [1:0] {
        CTRL_NONE, CTRL_BEQ, CTRL_BNE, CTRL_JUMP
    } ctrlE;

    // operand source seen by execute
    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwdSelE;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [XLEN-1:0]       rsVal;
        logic [XLEN-1:0]       rtVal;
        logic [XLEN-1:0]       imm;
        logic [4:0]            shamt;
        aluOpE                 aluOp;
        logic                  useImm;   // operand b from imm
        memOpE                 memOp;
        ctrlE                  ctrl;
        logic                  link;     // result is pc + 8
        logic                  regWrite;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       target;   // branch or jump destination
    } idExT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       storeData;
        memOpE                 memOp;
        logic                  regWrite;
        logic [REG_ADDR_W-1:0] dest;
    } exMemT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic                  regWrite;
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       result;
    } memWbT;

endpackage

/* source/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
    input  logic                     clk_i,
    input  logic                     arstN_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  logic                     redirect_i,
    input  logic [mipsPkg::XLEN-1:0] redirectPc_i,
    input  logic [mipsPkg::XLEN-1:0] instr_i,
    output logic [mipsPkg::XLEN-1:0] pc_o,
    output logic                     fetchEn_o,
    output mipsPkg::ifIdT            ifId_o
);
    logic [mipsPkg::XLEN-1:0] pcNext;

    assign pcNext    = redirect_i ? redirectPc_i : pc_o + 32'd4;
    assign fetchEn_o = arstN_i;  // fetching whenever out of reset

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            pc_o <= mipsPkg::RESET_PC;
        end else if (!stall_i) begin
            pc_o <= pcNext;
        end
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            ifId_o <= '0;
        end else if (flush_i) begin
            ifId_o <= '0;                      // zero word decodes as sll $0 which is a no-op
        end else if (!stall_i) begin
            ifId_o.pc    <= pc_o;
            ifId_o.instr <= instr_i;
        end
    end

endmodule

/* source/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit (
    input  logic                           clk_i,
    input  logic                           arstN_i,
    input  mipsPkg::ifIdT                  ifId_i,
    input  logic [mipsPkg::XLEN-1:0]       rsVal_i,
    input  logic [mipsPkg::XLEN-1:0]       rtVal_i,
    input  logic                           bubble_i,
    output logic [mipsPkg::REG_ADDR_W-1:0] rs_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] rt_o,
    output mipsPkg::idExT                  idEx_o
);
    logic [mipsPkg::XLEN-1:0] instr;
    logic [mipsPkg::XLEN-1:0] pcDelay;  // address of the delay slot
    logic [mipsPkg::XLEN-1:0] imm;
    logic signExt;
    mipsPkg::opcodeE opcode;
    mipsPkg::functE  funct;
    mipsPkg::idExT   dec;

    assign instr   = ifId_i.instr;
    assign opcode  = mipsPkg::opcodeE'(instr[31:26]);
    assign funct   = mipsPkg::functE'(instr[5:0]);
    assign rs_o    = instr[25:21];
    assign rt_o    = instr[20:16];
    assign pcDelay = ifId_i.pc + 32'd4;

    // logical immediates and lui keep the raw halfword
    assign signExt = !(opcode inside {mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_LUI});
    assign imm     = signExt ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};

    always_comb begin
        dec        = '0;
        dec.pc     = ifId_i.pc;
        dec.rs     = rs_o;
        dec.rt     = rt_o;
        dec.rsVal  = rsVal_i;
        dec.rtVal  = rtVal_i;
        dec.imm    = imm;
        dec.shamt  = instr[10:6];
        dec.dest   = rt_o;                             // I-format default
        dec.target = pcDelay + {imm[29:0], 2'b00};     // branch target
        case (opcode)
            mipsPkg::OP_SPECIAL: begin
                dec.regWrite = 1'b1;
                dec.dest     = instr[15:11];
                case (funct)
                    mipsPkg::FN_ADDU: dec.aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUBU: dec.aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND:  dec.aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:   dec.aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_XOR:  dec.aluOp = mipsPkg::ALU_XOR;
                    mipsPkg::FN_SLT:  dec.aluOp = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLL:  dec.aluOp = mipsPkg::ALU_SLL;
                    default:          dec.regWrite = 1'b0;  // unknown funct
                endcase
            end
            mipsPkg::OP_ADDIU, mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_LUI: begin
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                if (opcode == mipsPkg::OP_ANDI) dec.aluOp = mipsPkg::ALU_AND;
                if (opcode == mipsPkg::OP_ORI)  dec.aluOp = mipsPkg::ALU_OR;
                if (opcode == mipsPkg::OP_LUI)  dec.aluOp = mipsPkg::ALU_LUI;
            end
            mipsPkg::OP_LW, mipsPkg::OP_LB, mipsPkg::OP_LBU: begin
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                dec.memOp    = (opcode == mipsPkg::OP_LW) ? mipsPkg::MEM_LW :
                               (opcode == mipsPkg::OP_LB) ? mipsPkg::MEM_LB : mipsPkg::MEM_LBU;
            end
            mipsPkg::OP_SW, mipsPkg::OP_SB: begin
                dec.useImm = 1'b1;
                dec.memOp  = (opcode == mipsPkg::OP_SW) ? mipsPkg::MEM_SW : mipsPkg::MEM_SB;
            end
            mipsPkg::OP_BEQ: dec.ctrl = mipsPkg::CTRL_BEQ;
            mipsPkg::OP_BNE: dec.ctrl = mipsPkg::CTRL_BNE;
            mipsPkg::OP_J, mipsPkg::OP_JAL: begin
                dec.ctrl   = mipsPkg::CTRL_JUMP;
                dec.target = {pcDelay[31:28], instr[25:0], 2'b00};
                if (opcode == mipsPkg::OP_JAL) begin
                    dec.link     = 1'b1;
                    dec.regWrite = 1'b1;
                    dec.dest     = mipsPkg::RA_REG;
                end
            end
            default: dec.regWrite = 1'b0;              // anything else is a no-op
        endcase
        if (dec.dest == '0) dec.regWrite = 1'b0;      // $0 writes are dropped here
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            idEx_o <= '0;
        end else if (bubble_i) begin
            idEx_o <= '0;
        end else begin
            idEx_o <= dec;
        end
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                           clk_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rs_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rt_i,
    input  mipsPkg::memWbT                 wb_i,
    output logic [mipsPkg::XLEN-1:0]       rsVal_o,
    output logic [mipsPkg::XLEN-1:0]       rtVal_o
);
    logic [mipsPkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (wb_i.regWrite && wb_i.dest != '0) begin
            regs[wb_i.dest] <= wb_i.result;
        end
    end

    // $0 reads zero, a same-cycle write is passed through
    assign rsVal_o = (rs_i == '0) ? '0 :
                     (wb_i.regWrite && wb_i.dest == rs_i) ? wb_i.result : regs[rs_i];
    assign rtVal_o = (rt_i == '0) ? '0 :
                     (wb_i.regWrite && wb_i.dest == rt_i) ? wb_i.result : regs[rt_i];

endmodule

/* source/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
    input  logic                     clk_i,
    input  logic                     arstN_i,
    input  mipsPkg::idExT            idEx_i,
    input  mipsPkg::fwdSelE          fwdA_i,
    input  mipsPkg::fwdSelE          fwdB_i,
    input  mipsPkg::exMemT           memFwd_i,
    input  mipsPkg::memWbT           wbFwd_i,
    output logic                     redirect_o,
    output logic [mipsPkg::XLEN-1:0] redirectPc_o,
    output mipsPkg::exMemT           exMem_o
);
    logic [mipsPkg::XLEN-1:0] rsFwd, rtFwd, srcB, aluOut, result;

    function automatic logic [mipsPkg::XLEN-1:0] fwdMux(
        input mipsPkg::fwdSelE          sel,
        input logic [mipsPkg::XLEN-1:0] regVal,
        input mipsPkg::exMemT           memStage,
        input mipsPkg::memWbT           wbStage
    );
        case (sel)
            mipsPkg::FWD_MEM: return memStage.aluResult;
            mipsPkg::FWD_WB:  return wbStage.result;
            default:          return regVal;
        endcase
    endfunction

    assign rsFwd = fwdMux(fwdA_i, idEx_i.rsVal, memFwd_i, wbFwd_i);
    assign rtFwd = fwdMux(fwdB_i, idEx_i.rtVal, memFwd_i, wbFwd_i);
    assign srcB  = idEx_i.useImm ? idEx_i.imm : rtFwd;

    always_comb begin
        case (idEx_i.aluOp)
            mipsPkg::ALU_SUB: aluOut = rsFwd - srcB;
            mipsPkg::ALU_AND: aluOut = rsFwd & srcB;
            mipsPkg::ALU_OR:  aluOut = rsFwd | srcB;
            mipsPkg::ALU_XOR: aluOut = rsFwd ^ srcB;
            mipsPkg::ALU_SLT: aluOut = {31'b0, $signed(rsFwd) < $signed(srcB)};
            mipsPkg::ALU_SLL: aluOut = rtFwd << idEx_i.shamt;
            mipsPkg::ALU_LUI: aluOut = {srcB[15:0], 16'b0};
            default:          aluOut = rsFwd + srcB;   // add, also load/store address
        endcase
    end

    assign result = idEx_i.link ? idEx_i.pc + 32'd8 : aluOut;  // jal returns past the slot

    // resolved here, the slot in decode still runs
    always_comb begin
        case (idEx_i.ctrl)
            mipsPkg::CTRL_BEQ:  redirect_o = (rsFwd == rtFwd);
            mipsPkg::CTRL_BNE:  redirect_o = (rsFwd != rtFwd);
            mipsPkg::CTRL_JUMP: redirect_o = 1'b1;
            default:            redirect_o = 1'b0;
        endcase
    end
    assign redirectPc_o = idEx_i.target;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            exMem_o <= '0;
        end else begin
            exMem_o.pc        <= idEx_i.pc;
            exMem_o.aluResult <= result;
            exMem_o.storeData <= rtFwd;
            exMem_o.memOp     <= idEx_i.memOp;
            exMem_o.regWrite  <= idEx_i.regWrite;
            exMem_o.dest      <= idEx_i.dest;
        end
    end

endmodule

/* source/memAccess.sv */
`timescale 1ns/1ps

module memAccess (
    input  logic                     clk_i,
    input  logic                     arstN_i,
    input  mipsPkg::exMemT           exMem_i,
    input  logic [mipsPkg::XLEN-1:0] memRdata_i,
    output logic                     memEn_o,
    output logic [3:0]               memWen_o,
    output logic [mipsPkg::XLEN-1:0] memAddr_o,
    output logic [mipsPkg::XLEN-1:0] memWdata_o,
    output mipsPkg::memWbT           memWb_o
);
    logic [1:0]               lane;
    logic [7:0]               loadByte;
    logic [mipsPkg::XLEN-1:0] result;

    assign lane      = exMem_i.aluResult[1:0];
    assign memAddr_o = exMem_i.aluResult;
    assign memEn_o   = (exMem_i.memOp != mipsPkg::MEM_NONE);
    assign loadByte  = memRdata_i[lane*8 +: 8];   // little-endian lanes

    always_comb begin
        memWen_o   = 4'b0000;
        memWdata_o = exMem_i.storeData;
        result     = exMem_i.aluResult;
        case (exMem_i.memOp)
            mipsPkg::MEM_SW: memWen_o = 4'b1111;
            mipsPkg::MEM_SB: begin
                memWen_o   = 4'b0001 << lane;
                memWdata_o = {4{exMem_i.storeData[7:0]}};  // byte on every lane
            end
            mipsPkg::MEM_LW:  result = memRdata_i;
            mipsPkg::MEM_LB:  result = {{24{loadByte[7]}}, loadByte};
            mipsPkg::MEM_LBU: result = {24'b0, loadByte};
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            memWb_o <= '0;
        end else begin
            memWb_o.pc       <= exMem_i.pc;
            memWb_o.regWrite <= exMem_i.regWrite;
            memWb_o.dest     <= exMem_i.dest;
            memWb_o.result   <= result;
        end
    end

endmodule

/* source/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    input  mipsPkg::idExT                  idEx_i,
    input  mipsPkg::exMemT                 exMem_i,
    input  mipsPkg::memWbT                 memWb_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rsD_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtD_i,
    input  logic                           redirect_i,
    output logic                           stallF_o,
    output logic                           stallD_o,
    output logic                           bubbleE_o,
    output logic                           flushD_o,
    output mipsPkg::fwdSelE                fwdA_o,
    output mipsPkg::fwdSelE                fwdB_o
);
    logic memIsLoad, exIsLoad, loadUse;

    // nearest producer wins, load data only comes back from writeback
    function automatic mipsPkg::fwdSelE pickSrc(
        input logic [mipsPkg::REG_ADDR_W-1:0] src,
        input mipsPkg::exMemT                 memStage,
        input logic                           memLoad,
        input mipsPkg::memWbT                 wbStage
    );
        if (src == '0) return mipsPkg::FWD_REG;
        if (memStage.regWrite && memStage.dest == src && !memLoad) return mipsPkg::FWD_MEM;
        if (wbStage.regWrite && wbStage.dest == src) return mipsPkg::FWD_WB;
        return mipsPkg::FWD_REG;
    endfunction

    assign memIsLoad = exMem_i.memOp inside {mipsPkg::MEM_LW, mipsPkg::MEM_LB, mipsPkg::MEM_LBU};
    assign exIsLoad  = idEx_i.memOp inside {mipsPkg::MEM_LW, mipsPkg::MEM_LB, mipsPkg::MEM_LBU};

    assign fwdA_o = pickSrc(idEx_i.rs, exMem_i, memIsLoad, memWb_i);
    assign fwdB_o = pickSrc(idEx_i.rt, exMem_i, memIsLoad, memWb_i);

    // load in execute feeding decode costs one cycle
    assign loadUse = exIsLoad && idEx_i.regWrite &&
                     (idEx_i.dest == rsD_i || idEx_i.dest == rtD_i);

    assign stallF_o  = loadUse;
    assign stallD_o  = loadUse;
    assign bubbleE_o = loadUse;
    assign flushD_o  = redirect_i;  // kill the fetch after the delay slot

endmodule

/* source/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore (
    input  logic                               clk_i,
    input  logic                               arstN_i,
    // instruction port
    output logic [mipsPkg::XLEN-1:0]           pcF_o,
    output logic                               instEn_o,
    input  logic [mipsPkg::XLEN-1:0]           instr_i,
    // data port
    output logic                               memEn_o,
    output logic [3:0]                         memWen_o,
    output logic [mipsPkg::XLEN-1:0]           memAddr_o,
    output logic [mipsPkg::XLEN-1:0]           memWdata_o,
    input  logic [mipsPkg::XLEN-1:0]           memRdata_i,
    // writeback debug
    output logic [mipsPkg::XLEN-1:0]           debugWbPc_o,
    output logic                               debugWbRfWen_o,
    output logic [mipsPkg::REG_ADDR_W-1:0]     debugWbRfWnum_o,
    output logic [mipsPkg::XLEN-1:0]           debugWbRfWdata_o
);
    mipsPkg::ifIdT   ifId;
    mipsPkg::idExT   idEx;
    mipsPkg::exMemT  exMem;
    mipsPkg::memWbT  memWb;
    mipsPkg::fwdSelE fwdA, fwdB;

    logic [mipsPkg::REG_ADDR_W-1:0] rsD, rtD;
    logic [mipsPkg::XLEN-1:0]       rsValD, rtValD;
    logic [mipsPkg::XLEN-1:0]       redirectPc;
    logic stallF, bubbleE, flushD, redirect;

    fetchStage fetchStage_inst (
        .clk_i(clk_i), .arstN_i(arstN_i),
        .stall_i(stallF), .flush_i(flushD),
        .redirect_i(redirect), .redirectPc_i(redirectPc),
        .instr_i(instr_i),
        .pc_o(pcF_o), .fetchEn_o(instEn_o),
        .ifId_o(ifId)
    );

    decodeUnit decodeUnit_inst (
        .clk_i(clk_i), .arstN_i(arstN_i),
        .ifId_i(ifId),
        .rsVal_i(rsValD), .rtVal_i(rtValD),
        .bubble_i(bubbleE),
        .rs_o(rsD), .rt_o(rtD),
        .idEx_o(idEx)
    );

    regFile regFile_inst (
        .clk_i(clk_i),
        .rs_i(rsD), .rt_i(rtD),
        .wb_i(memWb),
        .rsVal_o(rsValD), .rtVal_o(rtValD)
    );

    executeUnit executeUnit_inst (
        .clk_i(clk_i), .arstN_i(arstN_i),
        .idEx_i(idEx),
        .fwdA_i(fwdA), .fwdB_i(fwdB),
        .memFwd_i(exMem), .wbFwd_i(memWb),
        .redirect_o(redirect), .redirectPc_o(redirectPc),
        .exMem_o(exMem)
    );

    memAccess memAccess_inst (
        .clk_i(clk_i), .arstN_i(arstN_i),
        .exMem_i(exMem),
        .memRdata_i(memRdata_i),
        .memEn_o(memEn_o), .memWen_o(memWen_o),
        .memAddr_o(memAddr_o), .memWdata_o(memWdata_o),
        .memWb_o(memWb)
    );

    hazardUnit hazardUnit_inst (
        .idEx_i(idEx), .exMem_i(exMem), .memWb_i(memWb),
        .rsD_i(rsD), .rtD_i(rtD),
        .redirect_i(redirect),
        .stallF_o(stallF), .stallD_o(), .bubbleE_o(bubbleE),  // IF/ID hold stalls decode
        .flushD_o(flushD),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

    // debug port straight off MEM/WB
    assign debugWbPc_o      = memWb.pc;
    assign debugWbRfWen_o   = memWb.regWrite;
    assign debugWbRfWnum_o  = memWb.dest;
    assign debugWbRfWdata_o = memWb.result;

endmodule

/* tb/mipsCore_asserts.sv */
`timescale 1ns/1ps

module mipsCoreAsserts (
    input logic                           clk_i,
    input logic                           arstN_i,
    input logic                           memEn_i,
    input logic [3:0]                     memWen_i,
    input logic [mipsPkg::XLEN-1:0]       wbPc_i,
    input logic                           wbWen_i,
    input logic [mipsPkg::REG_ADDR_W-1:0] wbNum_i
);
    int unsigned resetFails = 0;
    int unsigned strobeFails = 0;
    int unsigned laneFails = 0;
    int unsigned zeroFails = 0;
    int unsigned alignFails = 0;
    int unsigned failCount;

    assign failCount = resetFails + strobeFails + laneFails + zeroFails + alignFails;

    quietInReset: assert property (@(posedge clk_i)
        arstN_i || (!memEn_i && memWen_i == 4'b0000 && !wbWen_i))
    else begin
        resetFails++;
        $error("memory or writeback strobe active during reset");
    end

    wenNeedsEn: assert property (@(posedge clk_i) disable iff (!arstN_i)
        memWen_i == 4'b0000 || memEn_i)
    else begin
        strobeFails++;
        $error("byte write enable without memory enable");
    end

    // none, one byte lane or the whole word
    laneShape: assert property (@(posedge clk_i) disable iff (!arstN_i)
        $onehot0(memWen_i) || memWen_i == 4'b1111)
    else begin
        laneFails++;
        $error("byte write enable pattern is not a lane or a word");
    end

    noZeroWrite: assert property (@(posedge clk_i) disable iff (!arstN_i)
        !wbWen_i || wbNum_i != '0)
    else begin
        zeroFails++;
        $error("writeback to register 0 reached the debug port");
    end

    wbPcAligned: assert property (@(posedge clk_i) disable iff (!arstN_i)
        !wbWen_i || wbPc_i[1:0] == 2'b00)
    else begin
        alignFails++;
        $error("writeback pc is not word aligned");
    end

endmodule

bind mipsCore mipsCoreAsserts mipsCoreAsserts_inst (
    .clk_i(clk_i), .arstN_i(arstN_i),
    .memEn_i(memEn_o), .memWen_i(memWen_o),
    .wbPc_i(debugWbPc_o), .wbWen_i(debugWbRfWen_o), .wbNum_i(debugWbRfWnum_o)
);

/* tb/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;
    localparam int ROM_WORDS = 64;

    logic        clk;
    logic        arstN;
    logic [31:0] pcF, instr, memAddr, memWdata, memRdata;
    logic [31:0] dbgPc, dbgData, romOffset;
    logic [4:0]  dbgNum;
    logic [3:0]  memWen;
    logic        instEn, memEn, dbgWen;

    logic [31:0] rom [ROM_WORDS];
    string       romTag [ROM_WORDS];
    logic [31:0] ram [64];
    int          romLen;
    int          checkErrors = 0;
    int          waitErrors = 0;

    // expected writebacks in commit order
    logic [31:0] expPc [$];
    logic [4:0]  expNum [$];
    logic [31:0] expData [$];
    string       expTag [$];

    mipsCore mipsCore_inst (
        .clk_i(clk), .arstN_i(arstN),
        .pcF_o(pcF), .instEn_o(instEn), .instr_i(instr),
        .memEn_o(memEn), .memWen_o(memWen), .memAddr_o(memAddr),
        .memWdata_o(memWdata), .memRdata_i(memRdata),
        .debugWbPc_o(dbgPc), .debugWbRfWen_o(dbgWen),
        .debugWbRfWnum_o(dbgNum), .debugWbRfWdata_o(dbgData)
    );

    // both memories answer in the same cycle
    assign romOffset = pcF - mipsPkg::RESET_PC;
    assign instr     = (romOffset < 32'(4 * ROM_WORDS)) ? rom[romOffset[7:2]] : 32'h0;
    assign memRdata  = ram[memAddr[7:2]];

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return addr * 32'h0101_0101 + 32'h1357_9BDF;
    endfunction

    function automatic logic [31:0] rType(input mipsPkg::functE fn, input int rs, input int rt,
                                          input int rd, input int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] iType(input mipsPkg::opcodeE op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] jType(input mipsPkg::opcodeE op, input logic [31:0] addr);
        return {op, addr[27:2]};
    endfunction

    function automatic logic [31:0] pcAt(input int idx);
        return mipsPkg::RESET_PC + 32'(4 * idx);
    endfunction

    function automatic logic [31:0] refAluR(input logic [31:0] ins, input logic [31:0] a,
                                            input logic [31:0] b);
        case (ins[5:0])
            mipsPkg::FN_ADDU: return a + b;
            mipsPkg::FN_SUBU: return a - b;
            mipsPkg::FN_AND:  return a & b;
            mipsPkg::FN_OR:   return a | b;
            mipsPkg::FN_XOR:  return a ^ b;
            mipsPkg::FN_SLT:  return {31'h0, $signed(a) < $signed(b)};
            mipsPkg::FN_SLL:  return b << ins[10:6];
            default:          return 32'h0;
        endcase
    endfunction

    task automatic emit(input string tag, input logic [31:0] word);
        rom[6'(romLen)]    = word;
        romTag[6'(romLen)] = tag;
        romLen++;
    endtask

    task automatic buildProgram();
        logic [15:0] hi, lo, sm;
        int          p;
        hi = 16'($urandom);
        lo = 16'($urandom);
        sm = 16'($urandom);
        emit("alu", iType(mipsPkg::OP_LUI, 0, 1, hi));
        emit("alu", iType(mipsPkg::OP_ORI, 1, 1, lo));
        emit("alu", iType(mipsPkg::OP_ADDIU, 0, 2, sm));
        emit("fwd", rType(mipsPkg::FN_ADDU, 1, 2, 3, 0));   // distances 2 and 1
        emit("fwd", rType(mipsPkg::FN_SUBU, 3, 1, 4, 0));   // distance 1 and 3
        emit("fwd", rType(mipsPkg::FN_AND, 4, 2, 5, 0));
        emit("alu", rType(mipsPkg::FN_OR, 5, 3, 6, 0));
        emit("alu", rType(mipsPkg::FN_XOR, 6, 1, 7, 0));
        emit("alu", rType(mipsPkg::FN_SLT, 2, 1, 8, 0));
        emit("alu", rType(mipsPkg::FN_SLL, 0, 7, 9, 5));
        emit("alu", iType(mipsPkg::OP_ANDI, 9, 10, lo));
        emit("zero", iType(mipsPkg::OP_ADDIU, 0, 0, 16'd7));  // write to $0 is dropped
        emit("zero", rType(mipsPkg::FN_ADDU, 0, 0, 11, 0));
        emit("mem", iType(mipsPkg::OP_SW, 0, 1, 16'd16));
        emit("mem", iType(mipsPkg::OP_LW, 0, 12, 16'd16));
        emit("mem", rType(mipsPkg::FN_ADDU, 12, 12, 13, 0));  // load-use
        emit("mem", iType(mipsPkg::OP_ADDIU, 0, 14, 16'h00A5));
        emit("mem", iType(mipsPkg::OP_SB, 0, 14, 16'd33));
        emit("mem", iType(mipsPkg::OP_LB, 0, 15, 16'd33));
        emit("mem", iType(mipsPkg::OP_LBU, 0, 16, 16'd33));
        emit("mem", iType(mipsPkg::OP_LBU, 0, 17, 16'd34));   // neighbour lane keeps fill
        emit("branch", iType(mipsPkg::OP_BEQ, 12, 1, 16'd2));  // taken
        emit("branch", iType(mipsPkg::OP_ADDIU, 0, 18, 16'd1));
        emit("branch", iType(mipsPkg::OP_ADDIU, 0, 19, 16'd2));
        emit("branch", iType(mipsPkg::OP_BNE, 12, 1, 16'd2));  // not taken
        emit("branch", iType(mipsPkg::OP_ADDIU, 0, 20, 16'd3));
        emit("branch", iType(mipsPkg::OP_ADDIU, 0, 21, 16'd4));
        emit("branch", iType(mipsPkg::OP_BNE, 14, 0, 16'd2));  // taken
        emit("branch", iType(mipsPkg::OP_ADDIU, 0, 22, 16'd5));
        emit("branch", iType(mipsPkg::OP_ADDIU, 0, 23, 16'd6));
        emit("branch", iType(mipsPkg::OP_BEQ, 14, 0, 16'd2));  // not taken
        emit("branch", iType(mipsPkg::OP_ADDIU, 0, 24, 16'd7));
        p = romLen;
        emit("jump", jType(mipsPkg::OP_JAL, pcAt(p + 3)));
        emit("jump", iType(mipsPkg::OP_ADDIU, 0, 25, 16'd8));
        emit("jump", iType(mipsPkg::OP_ADDIU, 0, 26, 16'd9));
        p = romLen;
        emit("jump", jType(mipsPkg::OP_J, pcAt(p + 3)));
        emit("jump", iType(mipsPkg::OP_ADDIU, 0, 27, 16'd10));
        emit("jump", iType(mipsPkg::OP_ADDIU, 0, 28, 16'd11));
        emit("jump", rType(mipsPkg::FN_ADDU, 31, 0, 29, 0));  // reads the link value
    endtask

    // in-order model with one delay slot after every branch or jump
    task automatic runReference();
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] pc, npc, nnpc, ins, a, b, val, sImm, zImm, addr;
        logic [7:0]  byteVal;
        logic [4:0]  dest;
        int          idx;
        for (int r = 0; r < 32; r++) regs[r] = 32'h0;
        for (int w = 0; w < 64; w++) mem[w] = fillWord(32'(4 * w));
        pc  = mipsPkg::RESET_PC;
        npc = pc + 32'd4;
        for (int step = 0; step < 4 * ROM_WORDS; step++) begin
            idx = int'((pc - mipsPkg::RESET_PC) >> 2);
            if (idx >= romLen) break;
            ins     = rom[6'(idx)];
            a       = regs[ins[25:21]];
            b       = regs[ins[20:16]];
            sImm    = {{16{ins[15]}}, ins[15:0]};
            zImm    = {16'h0, ins[15:0]};
            addr    = a + sImm;
            byteVal = 8'(mem[addr[7:2]] >> {addr[1:0], 3'b000});
            val     = 32'h0;
            nnpc    = npc + 32'd4;
            dest    = (ins[31:26] inside {mipsPkg::OP_ADDIU, mipsPkg::OP_ANDI, mipsPkg::OP_ORI,
                       mipsPkg::OP_LUI, mipsPkg::OP_LW, mipsPkg::OP_LB, mipsPkg::OP_LBU}) ?
                      ins[20:16] : 5'd0;
            case (ins[31:26])
                mipsPkg::OP_SPECIAL: begin
                    val  = refAluR(ins, a, b);
                    dest = (ins[5:0] inside {mipsPkg::FN_SLL, mipsPkg::FN_ADDU, mipsPkg::FN_SUBU,
                            mipsPkg::FN_AND, mipsPkg::FN_OR, mipsPkg::FN_XOR, mipsPkg::FN_SLT}) ?
                           ins[15:11] : 5'd0;
                end
                mipsPkg::OP_ADDIU: val = a + sImm;
                mipsPkg::OP_ANDI:  val = a & zImm;
                mipsPkg::OP_ORI:   val = a | zImm;
                mipsPkg::OP_LUI:   val = {ins[15:0], 16'h0};
                mipsPkg::OP_LW:    val = mem[addr[7:2]];
                mipsPkg::OP_LB:    val = {{24{byteVal[7]}}, byteVal};
                mipsPkg::OP_LBU:   val = {24'h0, byteVal};
                mipsPkg::OP_SW:    mem[addr[7:2]] = b;
                mipsPkg::OP_SB:    mem[addr[7:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
                mipsPkg::OP_BEQ:   nnpc = (a == b) ? npc + (sImm << 2) : nnpc;
                mipsPkg::OP_BNE:   nnpc = (a != b) ? npc + (sImm << 2) : nnpc;
                mipsPkg::OP_J:     nnpc = {npc[31:28], ins[25:0], 2'b00};
                mipsPkg::OP_JAL: begin
                    nnpc = {npc[31:28], ins[25:0], 2'b00};
                    val  = pc + 32'd8;          // return lands past the slot
                    dest = mipsPkg::RA_REG;
                end
                default: ;
            endcase
            if (dest != 5'd0) begin
                regs[dest] = val;
                expPc.push_back(pc);
                expNum.push_back(dest);
                expData.push_back(val);
                expTag.push_back(romTag[6'(idx)]);
            end
            pc  = npc;
            npc = nnpc;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // byte-lane data RAM written mid-cycle
    always @(negedge clk) begin
        for (int l = 0; l < 4; l++) begin
            if (memEn && memWen[l]) ram[memAddr[7:2]][l*8 +: 8] = memWdata[l*8 +: 8];
        end
    end

    // instruction fetch is enabled exactly when out of reset
    always @(posedge clk) begin
        assert (instEn == arstN) else begin
            checkErrors++;
            $display("Mismatch reset: expected instEn %b, actual %b", arstN, instEn);
        end
    end

    always @(negedge clk) begin
        if (arstN && dbgWen) begin
            assert (expPc.size() > 0) else begin
                checkErrors++;
                $display("unexpected writeback of r%0d at pc %h", dbgNum, dbgPc);
            end
            if (expPc.size() > 0) begin
                assert (dbgPc == expPc[0] && dbgNum == expNum[0] && dbgData == expData[0])
                else begin
                    checkErrors++;
                    $display("Mismatch %s: expected pc %h r%0d = %h, actual pc %h r%0d = %h",
                             expTag[0], expPc[0], expNum[0], expData[0], dbgPc, dbgNum, dbgData);
                end
                void'(expPc.pop_front());
                void'(expNum.pop_front());
                void'(expData.pop_front());
                void'(expTag.pop_front());
            end
        end
    end

    initial begin
        int          waitCycles;
        int unsigned assertFails;
        void'($urandom(32'h9f63));
        arstN  = 1'b0;
        romLen = 0;
        for (int w = 0; w < ROM_WORDS; w++) begin
            rom[w] = 32'h0;                   // unused words fetch as no-ops
            ram[w] = fillWord(32'(4 * w));
        end
        buildProgram();
        runReference();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        waitCycles = 0;
        while (expPc.size() > 0 && waitCycles < 400) begin
            @(negedge clk);
            waitCycles++;
        end
        if (expPc.size() > 0) begin
            waitErrors++;
            $display("timed out with %0d writebacks still expected", expPc.size());
        end
        @(posedge clk);
        assertFails = mipsCore_inst.mipsCoreAsserts_inst.failCount;
        $display("errors: %0d writeback, %0d timeout, %0d assertion",
                 checkErrors, waitErrors, assertFails);
        if (checkErrors == 0 && waitErrors == 0 && assertFails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/mipsPkg.sv
source/fetchStage.sv
source/decodeUnit.sv
source/regFile.sv
source/executeUnit.sv
source/memAccess.sv
source/hazardUnit.sv
source/mipsCore.sv
tb/mipsCore_asserts.sv
tb/mipsCoreTb.sv

/* Makefile */
TOP = mipsCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^All checks passed$$"

clean:
	rm -rf obj_dir
